// File: flist.f
+incdir+logic
logic/mul_types_pkg.sv
logic/mul_op_pkg.sv
logic/mul_decode.sv
logic/mul_pp_gen.sv
logic/mul_reduce_tree.sv
logic/mul_result.sv
logic/mul_unit.sv
sim/mul_unit_tb.sv

// File: sim/mul_unit_tb.sv
// Random-stimulus testbench for the multiply unit, checks every result against a local model
`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module mul_unit_tb
  import mul_types_pkg::*;
;

  localparam int unsigned NUM_OPS = 2000;
  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned IDLE_CYCLES = 8;
  localparam int unsigned WATCHDOG_CYCLES = NUM_OPS * 4 + `MUL_LATENCY + 20;
  localparam logic [31:0] SEED = 32'hb35da17c;

  // One outstanding operation as the model predicts it
  typedef struct packed {
    word_t       result;
    tag_t        rd;
    logic        ovf;
    logic        ill;
    logic [31:0] issue_edge;
  } expect_t;

  logic    clk = 1'b0;
  logic    arst_n;
  logic    start;
  funct3_t funct3;
  word_t   rs1_val;
  word_t   rs2_val;
  tag_t    rd;
  logic    done;
  word_t   result;
  tag_t    rd_out;
  logic    overflow;
  logic    illegal;

  // Scoreboard, oldest issue at the front
  expect_t     pending[$];
  int unsigned completed = 0;
  // Rising edges seen so far
  logic [31:0] edge_cnt = '0;

  mul_unit mul_unit_i (
    .clk, .arst_n, .start, .funct3, .rs1_val, .rs2_val, .rd,
    .done, .result, .rd_out, .overflow, .illegal
  );

  // 100 ns clock
  initial
  begin
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    edge_cnt <= edge_cnt + 1;
  end

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // Compare one observed value with the model
  task automatic check_equal(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("[ERROR] %0t ns: %s mismatch, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      abort_run();
    end
  endtask

  // Corner values show up about half the time
  function automatic word_t random_operand();
    int unsigned pick;
    pick = $urandom_range(0, 9);
    case (pick)
      0: return 32'h0000_0000;
      1: return 32'h0000_0001;
      2: return 32'hffff_ffff;
      3: return 32'h8000_0000;
      4: return 32'h7fff_ffff;
      default: return $urandom;
    endcase
  endfunction

  // Mostly multiplies, one in five from the divider range
  function automatic funct3_t random_funct3();
    int unsigned pick;
    pick = $urandom_range(0, 9);
    if (pick < 8)
      return funct3_t'(pick[1:0]);
    else
      return funct3_t'($urandom_range(4, 7));
  endfunction

  // Reference product built from sign or zero extended operands
  function automatic expect_t model_op(input funct3_t f3, input word_t a, input word_t b,
                                       input tag_t dest, input logic [31:0] issue);
    expect_t     e;
    logic        a_sgn;
    logic        b_sgn;
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] full;
    a_sgn = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd2);
    b_sgn = (f3 == 3'd0) || (f3 == 3'd1);
    ext_a = {{32{a_sgn & a[31]}}, a};
    ext_b = {{32{b_sgn & b[31]}}, b};
    // Low 64 bits of the product are the same for any signedness
    full = ext_a * ext_b;
    e.rd = dest;
    e.issue_edge = issue;
    e.ill = f3[2];
    if (f3[2])
    begin
      e.result = '0;
      e.ovf = 1'b0;
    end
    else if (f3 == 3'd0)
    begin
      e.result = full[31:0];
      e.ovf = (full[63:32] != {32{full[31]}});
    end
    else
    begin
      e.result = full[63:32];
      e.ovf = 1'b0;
    end
    return e;
  endfunction

  // Drive one operation, the unit samples it on the next rising edge
  task automatic issue_op();
    start = 1'b1;
    funct3 = random_funct3();
    rs1_val = random_operand();
    rs2_val = random_operand();
    rd = tag_t'($urandom);
    pending.push_back(model_op(funct3, rs1_val, rs2_val, rd, edge_cnt + 1));
  endtask

  // Monitor samples outputs mid-cycle where they are stable
  always @(negedge clk)
  begin : monitor
    expect_t exp_item;
    if (arst_n === 1'b1 && done === 1'b1)
    begin
      if (pending.size() == 0)
      begin
        $display("done went high at %0t ns with no operation outstanding", $time);
        abort_run();
      end
      else
      begin
        exp_item = pending.pop_front();
        check_equal("result", result, exp_item.result);
        check_equal("rd_out", rd_out, exp_item.rd);
        check_equal("overflow", overflow, exp_item.ovf);
        check_equal("illegal", illegal, exp_item.ill);
        // Start edge and done edge both counted
        check_equal("latency", edge_cnt - exp_item.issue_edge + 1, `MUL_LATENCY);
        completed++;
      end
    end
  end

  // Limit counted from reset release
  initial
  begin : watchdog
    @(posedge arst_n);
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d results returned",
             WATCHDOG_CYCLES, completed, NUM_OPS);
    abort_run();
  end

  initial
  begin : stimulus
    int unsigned gap;
    void'($urandom(SEED));
    arst_n = 1'b0;
    start = 1'b0;
    funct3 = '0;
    rs1_val = '0;
    rs2_val = '0;
    rd = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    // No done before the first start
    repeat (IDLE_CYCLES)
    begin
      @(negedge clk);
      check_equal("done while idle", done, 1'b0);
    end
    for (int n = 0; n < NUM_OPS; n++)
    begin
      gap = $urandom_range(0, 3);
      issue_op();
      @(negedge clk);
      start = 1'b0;
      repeat (gap) @(negedge clk);
    end
    // Drain the pipeline
    while (pending.size() != 0) @(negedge clk);
    @(negedge clk);
    if (completed == NUM_OPS)
    begin
      $display("*** PASSED ***");
      $finish;
    end
    else
    begin
      $display("Only %0d of %0d results returned", completed, NUM_OPS);
      abort_run();
    end
  end

endmodule

`default_nettype wire

// File: logic/mul_unit.sv
// Top level of the pipelined multiply unit, chains decode, execute and result stages
`timescale 1ns/10ps
`default_nettype none

module mul_unit
  import mul_types_pkg::*, mul_op_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    arst_n,
  input  wire logic    start,
  input  wire funct3_t funct3,
  input  wire word_t   rs1_val,
  input  wire word_t   rs2_val,
  input  wire tag_t    rd,
  output logic         done,
  output word_t        result,
  output tag_t         rd_out,
  output logic         overflow,
  output logic         illegal
);

  // Stage records, each driven from its producer's registers
  mul_cmd_t  cmd;
  mul_pp_t   pp;
  mul_prod_t prod;

  mul_decode mul_decode_i (
    .clk, .arst_n, .start, .funct3, .rs1_val, .rs2_val, .rd,
    .cmd
  );

  // Execute, split into generation and reduction
  mul_pp_gen mul_pp_gen_i (
    .clk, .arst_n, .cmd,
    .pp
  );

  mul_reduce_tree mul_reduce_tree_i (
    .clk, .arst_n, .pp,
    .prod
  );

  mul_result mul_result_i (
    .clk, .arst_n, .prod,
    .done, .result, .rd_out, .overflow, .illegal
  );

endmodule

`default_nettype wire

// File: logic/mul_result.sv
// Result stage, restores the sign, picks the word and drives the unit outputs from registers
`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module mul_result
  import mul_types_pkg::*, mul_op_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      arst_n,
  input  wire mul_prod_t prod,
  output logic           done,
  output word_t          result,
  output tag_t           rd_out,
  output logic           overflow,
  output logic           illegal
);

  dword_t sprod;
  word_t  hi_w;
  word_t  lo_w;
  word_t  result_c;
  logic   ovf_c;

  // Two's complement of the magnitude when the operand signs differ
  assign sprod = prod.meta.neg ? dword_t'(-prod.mag_prod) : prod.mag_prod;

  assign hi_w = sprod[2*`MUL_WORD_WIDTH-1:`MUL_WORD_WIDTH];
  assign lo_w = sprod[`MUL_WORD_WIDTH-1:0];

  always_comb
  begin
    result_c = prod.meta.sel_high ? hi_w : lo_w;
    // MUL overflows when the upper word is not the sign fill of the low word
    ovf_c = prod.meta.chk_ovf && (hi_w != {`MUL_WORD_WIDTH{lo_w[`MUL_WORD_WIDTH-1]}});
    if (prod.meta.illegal)
    begin
      result_c = '0;
      ovf_c    = 1'b0;
    end
  end

  // Status flags
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      done     <= 1'b0;
      overflow <= 1'b0;
      illegal  <= 1'b0;
    end
    else
    begin
      done     <= prod.meta.valid;
      overflow <= ovf_c;
      illegal  <= prod.meta.illegal;
    end
  end

  // Payload, only meaningful while done is high
  always_ff @(posedge clk)
  begin
    result <= result_c;
    rd_out <= prod.meta.rd;
  end

endmodule

`default_nettype wire

// File: logic/mul_reduce_tree.sv
// Second execute stage, three registered four-input adder levels reduce the partial products
`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module mul_reduce_tree
  import mul_types_pkg::*, mul_op_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    arst_n,
  input  wire mul_pp_t pp,
  output mul_prod_t    prod
);

  // 64 partial products, then 16, then 4, then 1
  localparam int unsigned L1_SUMS = `MUL_NUM_PP / 4;
  localparam int unsigned L2_SUMS = L1_SUMS / 4;

  // Per-level meta, so each level holds its own item
  mul_meta_t meta1_q;
  mul_meta_t meta2_q;
  mul_meta_t meta3_q;

  dword_t [L1_SUMS-1:0] lvl1_q;
  dword_t [L2_SUMS-1:0] lvl2_q;
  dword_t               lvl3_q;

  // Full 64-bit sum, no carries lost at any level
  function automatic dword_t add4(input dword_t a, input dword_t b,
                                  input dword_t c, input dword_t d);
    return a + b + c + d;
  endfunction

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      meta1_q <= '0;
      meta2_q <= '0;
      meta3_q <= '0;
    end
    else
    begin
      meta1_q <= pp.meta;
      meta2_q <= meta1_q;
      meta3_q <= meta2_q;
    end
  end

  // Level 1, groups of four neighbouring partial products
  always_ff @(posedge clk)
  begin
    for (int k = 0; k < L1_SUMS; k++)
    begin
      lvl1_q[k] <= add4(pp.part[4*k], pp.part[4*k+1], pp.part[4*k+2], pp.part[4*k+3]);
    end
  end

  // Level 2
  always_ff @(posedge clk)
  begin
    for (int k = 0; k < L2_SUMS; k++)
    begin
      lvl2_q[k] <= add4(lvl1_q[4*k], lvl1_q[4*k+1], lvl1_q[4*k+2], lvl1_q[4*k+3]);
    end
  end

  // Level 3 gives the magnitude product
  always_ff @(posedge clk)
  begin
    lvl3_q <= add4(lvl2_q[0], lvl2_q[1], lvl2_q[2], lvl2_q[3]);
  end

  assign prod = '{meta: meta3_q, mag_prod: lvl3_q};

endmodule

`default_nettype wire

// File: logic/mul_pp_gen.sv
// First execute stage, builds and registers every shifted nibble-by-nibble partial product
`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module mul_pp_gen
  import mul_types_pkg::*, mul_op_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     arst_n,
  input  wire mul_cmd_t cmd,
  output mul_pp_t       pp
);

  localparam int unsigned NIB = `MUL_NIBBLE_WIDTH;
  localparam int unsigned NUM_NIB = `MUL_NUM_NIBBLES;

  dword_t [`MUL_NUM_PP-1:0] part_c;

  mul_meta_t                meta_q;
  dword_t [`MUL_NUM_PP-1:0] part_q;

  // Nibble i of a times nibble j of b, weighted by 16 to the power i plus j
  always_comb
  begin
    nibble_t a_nib;
    nibble_t b_nib;
    dword_t  raw;
    for (int i = 0; i < NUM_NIB; i++)
    begin
      for (int j = 0; j < NUM_NIB; j++)
      begin
        a_nib = cmd.mag_a[i*NIB +: NIB];
        b_nib = cmd.mag_b[j*NIB +: NIB];
        // Widen first so the 8-bit product is kept whole
        raw = dword_t'(a_nib) * dword_t'(b_nib);
        part_c[i*NUM_NIB + j] = raw << (NIB * (i + j));
      end
    end
  end

  // Meta moves with the data, one item per cycle
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      meta_q <= '0;
    else
      meta_q <= cmd.meta;
  end

  always_ff @(posedge clk)
  begin
    part_q <= part_c;
  end

  assign pp = '{meta: meta_q, part: part_q};

endmodule

`default_nettype wire

// File: logic/mul_decode.sv
// Decode stage, turns funct3 and the raw operands into a registered unsigned command
`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module mul_decode
  import mul_types_pkg::*, mul_op_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    arst_n,
  input  wire logic    start,
  input  wire funct3_t funct3,
  input  wire word_t   rs1_val,
  input  wire word_t   rs2_val,
  input  wire tag_t    rd,
  output mul_cmd_t     cmd
);

  mul_op_e   op;
  logic      a_signed;
  logic      b_signed;
  logic      a_neg;
  logic      b_neg;
  mul_meta_t meta_c;
  word_t     mag_a_c;
  word_t     mag_b_c;

  mul_meta_t meta_q;
  word_t     mag_a_q;
  word_t     mag_b_q;

  // funct3 4 to 7 belong to the divider, low two bits pick the multiply
  assign op = mul_op_e'({1'b0, funct3[1:0]});

  // MULHU treats both operands as unsigned, MULHSU only the second
  assign a_signed = (op != MUL_OP_MULHU);
  assign b_signed = (op == MUL_OP_MUL) || (op == MUL_OP_MULH);

  assign a_neg = a_signed && rs1_val[`MUL_WORD_WIDTH-1];
  assign b_neg = b_signed && rs2_val[`MUL_WORD_WIDTH-1];

  always_comb
  begin
    meta_c.valid    = start;
    meta_c.illegal  = funct3[2];
    meta_c.neg      = !funct3[2] && (a_neg ^ b_neg);
    meta_c.sel_high = !funct3[2] && (op != MUL_OP_MUL);
    meta_c.chk_ovf  = !funct3[2] && (op == MUL_OP_MUL);
    meta_c.rd       = rd;
    // Absolute values, 0x80000000 stays as its own magnitude
    mag_a_c = a_neg ? word_t'(-rs1_val) : rs1_val;
    mag_b_c = b_neg ? word_t'(-rs2_val) : rs2_val;
    // Illegal items flow through with a zero product
    if (funct3[2])
    begin
      mag_a_c = '0;
      mag_b_c = '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      meta_q <= '0;
    else
      meta_q <= meta_c;
  end

  // Operand magnitudes
  always_ff @(posedge clk)
  begin
    mag_a_q <= mag_a_c;
    mag_b_q <= mag_b_c;
  end

  assign cmd = '{meta: meta_q, mag_a: mag_a_q, mag_b: mag_b_q};

endmodule

`default_nettype wire

// File: logic/mul_op_pkg.sv
// Operation codes and stage-to-stage records of the multiply pipeline
`default_nettype none

`include "mul_defs.svh"

package mul_op_pkg;

  import mul_types_pkg::*;

  // M-extension multiply group, values equal funct3
  typedef enum funct3_t {
    MUL_OP_MUL    = 3'd0,
    MUL_OP_MULH   = 3'd1,
    MUL_OP_MULHSU = 3'd2,
    MUL_OP_MULHU  = 3'd3
  } mul_op_e;

  // Control that rides beside the data in every stage
  typedef struct packed {
    logic valid;
    logic illegal;
    // Product has to be negated in the result stage
    logic neg;
    logic sel_high;
    // Only MUL reports overflow
    logic chk_ovf;
    tag_t rd;
  } mul_meta_t;

  // Decode to partial-product generation
  typedef struct packed {
    mul_meta_t meta;
    word_t     mag_a;
    word_t     mag_b;
  } mul_cmd_t;

  // Partial-product generation to reduction tree
  typedef struct packed {
    mul_meta_t                    meta;
    dword_t [`MUL_NUM_PP-1:0] part;
  } mul_pp_t;

  // Reduction tree to result stage, unsigned magnitude product
  typedef struct packed {
    mul_meta_t meta;
    dword_t    mag_prod;
  } mul_prod_t;

endpackage

`default_nettype wire

// File: logic/mul_types_pkg.sv
// Plain vector types for the data widths of the multiply unit, imported by every stage
`default_nettype none

`include "mul_defs.svh"

package mul_types_pkg;

  // One operand or one result word
  typedef logic [`MUL_WORD_WIDTH-1:0] word_t;

  // Full product, also the width of every shifted partial product
  typedef logic [2*`MUL_WORD_WIDTH-1:0] dword_t;

  // One operand slice
  typedef logic [`MUL_NIBBLE_WIDTH-1:0] nibble_t;

  // Destination register index, carried through untouched
  typedef logic [`MUL_TAG_WIDTH-1:0] tag_t;

  // RISC-V funct3 field of the OP instruction
  typedef logic [2:0] funct3_t;

endpackage

`default_nettype wire

// File: logic/mul_defs.svh
// Width and latency macros for the multiply unit, included by the packages, RTL and testbench
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// Operand width, one RISC-V register
`define MUL_WORD_WIDTH 32

// Slice width used to split each operand
`define MUL_NIBBLE_WIDTH 4

// Nibbles per operand, 8 for a 32-bit word
`define MUL_NUM_NIBBLES (`MUL_WORD_WIDTH / `MUL_NIBBLE_WIDTH)

// Partial products, one per nibble pair
`define MUL_NUM_PP (`MUL_NUM_NIBBLES * `MUL_NUM_NIBBLES)

// Destination register index width
`define MUL_TAG_WIDTH 5

// Clock edges from the start edge to the done edge
// decode 1, partial products 1, tree 3, result 1
`define MUL_LATENCY 6

`endif
